// ==== Makefile ====
TOP := branch_predictor_tb

.PHONY: lint sim clean

# Lint the testbench and the RTL top level on its own
lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)
	verilator --lint-only --timing -f files.f --top-module branch_predictor

# The run passes only when the pass message shows up in the output
sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// ==== dv/branch_predictor_chk.sv ====
// ----------------------------------------------------------
// Protocol assertions for the branch predictor
// Bound to the top level from the testbench
// ----------------------------------------------------------

`default_nettype none

module branch_predictor_chk (
    input logic                         clk_i,
    input logic                         arst_n_i,
    input logic                         lookup_valid_i,
    input logic                         pred_valid_i,
    input branch_pred_pkg::prediction_t pred_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // Every lookup comes back exactly two edges later, and nothing else does
    latency_two: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pred_valid_i == $past(lookup_valid_i, 2))
        else $error("prediction strobe does not follow the lookup by two cycles");

    // The output strobe stays quiet while reset is held
    quiet_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !pred_valid_i)
        else $error("prediction strobe seen during reset");

    // Only a buffer hit can redirect fetch
    taken_needs_hit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (pred_valid_i && pred_i.taken) |-> pred_i.hit)
        else $error("taken prediction without a hit");

endmodule : branch_predictor_chk

`default_nettype wire

// ==== dv/branch_predictor_tb.sv ====
// ----------------------------------------------------------
// Testbench for the branch predictor
// Runs directed phases and a random stream, checking every
// prediction in order against a reference model
// ----------------------------------------------------------

`default_nettype none

`include "bpu_consts.svh"

module branch_predictor_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import core_addr_pkg::*;
    import branch_pred_pkg::*;

    localparam int BTB_IDX_W = $clog2(`BPU_BTB_ENTRIES);
    localparam int BHT_IDX_W = $clog2(`BPU_BHT_ENTRIES);
    localparam int CNT_MAX = (1 << `BPU_CNT_W) - 1;
    // About 4000 random cycles plus the directed phases, with a wide margin
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int RANDOM_CYCLES = 4000;

    logic        clk_i;
    logic        arst_n_i;
    logic        lookup_valid_i;
    lookup_t     lookup_i;
    logic        update_valid_i;
    update_t     update_i;
    logic        pred_valid_o;
    prediction_t pred_o;

    // Reference state, indexed the same way fetch addresses map to the tables
    logic                  ref_btb_valid [`BPU_BTB_ENTRIES];
    addr_t                 ref_btb_tag [`BPU_BTB_ENTRIES];
    addr_t                 ref_btb_target [`BPU_BTB_ENTRIES];
    logic                  ref_btb_jump [`BPU_BTB_ENTRIES];
    logic                  ref_cnt_valid [`BPU_BHT_ENTRIES];
    logic [`BPU_CNT_W-1:0] ref_cnt [`BPU_BHT_ENTRIES];

    // Expected predictions with the cycle of their lookup
    prediction_t exp_q [$];
    int          stamp_q [$];
    int          cycle_cnt = 0;

    branch_predictor branch_predictor_inst (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .lookup_valid_i (lookup_valid_i),
        .lookup_i       (lookup_i),
        .update_valid_i (update_valid_i),
        .update_i       (update_i),
        .pred_valid_o   (pred_valid_o),
        .pred_o         (pred_o)
    );

    bind branch_predictor branch_predictor_chk chk_inst (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .lookup_valid_i (lookup_valid_i),
        .pred_valid_i   (pred_valid_o),
        .pred_i         (pred_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------

    function automatic prediction_t predict(input addr_t pc);
        prediction_t           p;
        logic [BTB_IDX_W-1:0]  bi;
        logic [BHT_IDX_W-1:0]  ci;
        logic [`BPU_CNT_W-1:0] cnt;
        logic                  hit;
        bi = pc[BTB_IDX_W:1];
        ci = pc[BHT_IDX_W:1];
        hit = ref_btb_valid[bi] && (ref_btb_tag[bi] == (pc >> (BTB_IDX_W + 1)));
        cnt = ref_cnt_valid[ci] ? ref_cnt[ci] : `BPU_CNT_W'(`BPU_CNT_INIT);
        p.hit = hit;
        p.taken = hit && (ref_btb_jump[bi] || cnt >= 2);
        p.pc = pc;
        p.next_pc = p.taken ? ref_btb_target[bi] : pc + 4;
        return p;
    endfunction

    task automatic apply_update(input update_t u);
        logic [BTB_IDX_W-1:0]  bi;
        logic [BHT_IDX_W-1:0]  ci;
        logic [`BPU_CNT_W-1:0] cnt;
        bi = u.instr_addr[BTB_IDX_W:1];
        ci = u.instr_addr[BHT_IDX_W:1];
        if ((u.is_branch && u.taken) || u.is_jump) begin
            ref_btb_valid[bi] = 1'b1;
            ref_btb_tag[bi] = u.instr_addr >> (BTB_IDX_W + 1);
            ref_btb_target[bi] = u.target;
            ref_btb_jump[bi] = u.is_jump;
        end
        if (u.is_branch) begin
            cnt = ref_cnt_valid[ci] ? ref_cnt[ci] : `BPU_CNT_W'(`BPU_CNT_INIT);
            if (u.taken && cnt != CNT_MAX) begin
                cnt = cnt + 1'b1;
            end else if (!u.taken && cnt != 0) begin
                cnt = cnt - 1'b1;
            end
            ref_cnt[ci] = cnt;
            ref_cnt_valid[ci] = 1'b1;
        end
    endtask

    // ----------------------------------------------------------
    // Checking
    // ----------------------------------------------------------

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_prediction(input prediction_t got, input prediction_t exp);
        bit bad;
        bad = 1'b0;
        if (got.next_pc !== exp.next_pc) begin
            $display("[FAIL] pred_o.next_pc got 0x%h expected 0x%h", got.next_pc, exp.next_pc);
            bad = 1'b1;
        end
        if (got.taken !== exp.taken) begin
            $display("[FAIL] pred_o.taken got 0x%h expected 0x%h", got.taken, exp.taken);
            bad = 1'b1;
        end
        if (got.hit !== exp.hit) begin
            $display("[FAIL] pred_o.hit got 0x%h expected 0x%h", got.hit, exp.hit);
            bad = 1'b1;
        end
        if (got.pc !== exp.pc) begin
            $display("[FAIL] pred_o.pc got 0x%h expected 0x%h", got.pc, exp.pc);
            bad = 1'b1;
        end
        if (bad) begin
            report_failure("Prediction does not match the reference model");
        end
    endtask

    // The model samples at the same edge as the DUT, lookup before update
    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            report_failure("Timeout, the run did not finish within the cycle limit");
        end else if (arst_n_i) begin
            if (lookup_valid_i) begin
                exp_q.push_back(predict(lookup_i.pc));
                stamp_q.push_back(cycle_cnt);
            end
            if (update_valid_i) begin
                apply_update(update_i);
            end
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk_i) begin
        if (arst_n_i) begin
            if (pred_valid_o) begin
                if (exp_q.size() == 0) begin
                    report_failure("A prediction arrived with no lookup outstanding");
                end else if (stamp_q[0] + 1 != cycle_cnt) begin
                    report_failure("A prediction arrived at the wrong cycle");
                end else begin
                    void'(stamp_q.pop_front());
                    check_prediction(pred_o, exp_q.pop_front());
                end
            end else if (exp_q.size() != 0 && stamp_q[0] + 1 <= cycle_cnt) begin
                report_failure("An expected prediction did not arrive");
            end
        end
    end

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------

    function automatic update_t make_update(input addr_t a, input addr_t t,
                                            input logic br, input logic jmp,
                                            input logic tk);
        update_t u;
        u.instr_addr = a;
        u.target = t;
        u.is_branch = br;
        u.is_jump = jmp;
        u.taken = tk;
        return u;
    endfunction

    // Four tags over four buffer indexes, with halfword offsets now and then
    function automatic addr_t pool_addr();
        int unsigned i;
        i = $urandom % 16;
        return 32'h0000_8000 + addr_t'((i % 4) << 9) + addr_t'((i / 4) << 2)
               + addr_t'(($urandom % 2) << 1);
    endfunction

    task automatic drive_cycle(input logic lv, input addr_t pc, input logic uv,
                               input update_t u);
        @(negedge clk_i);
        lookup_valid_i = lv;
        lookup_i.pc = pc;
        update_valid_i = uv;
        update_i = u;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, '0, 1'b0, '0);
    endtask

    task automatic branch_update(input addr_t a, input logic tk);
        drive_cycle(1'b0, '0, 1'b1, make_update(a, 32'h0000_3100, 1'b1, 1'b0, tk));
    endtask

    initial begin
        update_t u;
        void'($urandom(82282));
        arst_n_i = 1'b0;
        lookup_valid_i = 1'b0;
        lookup_i = '0;
        update_valid_i = 1'b0;
        update_i = '0;
        for (int i = 0; i < `BPU_BTB_ENTRIES; i++) begin
            ref_btb_valid[i] = 1'b0;
        end
        for (int i = 0; i < `BPU_BHT_ENTRIES; i++) begin
            ref_cnt_valid[i] = 1'b0;
        end
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;

        // Cold tables miss everywhere
        for (int i = 0; i < 16; i++) begin
            drive_cycle(1'b1, addr_t'($urandom) & ~addr_t'(1), 1'b0, '0);
        end

        // Jump written, then looked up
        drive_cycle(1'b0, '0, 1'b1,
                    make_update(32'h0000_1000, 32'h0000_2040, 1'b0, 1'b1, 1'b1));
        drive_cycle(1'b1, 32'h0000_1000, 1'b0, '0);

        // Branch training walks the counter through both ends of its range
        branch_update(32'h0000_3008, 1'b1);
        drive_cycle(1'b1, 32'h0000_3008, 1'b0, '0);
        branch_update(32'h0000_3008, 1'b0);
        branch_update(32'h0000_3008, 1'b0);
        drive_cycle(1'b1, 32'h0000_3008, 1'b0, '0);
        branch_update(32'h0000_3008, 1'b0);
        branch_update(32'h0000_3008, 1'b1);
        drive_cycle(1'b1, 32'h0000_3008, 1'b0, '0);
        branch_update(32'h0000_3008, 1'b1);
        drive_cycle(1'b1, 32'h0000_3008, 1'b0, '0);
        repeat (3) branch_update(32'h0000_3008, 1'b1);
        branch_update(32'h0000_3008, 1'b0);
        drive_cycle(1'b1, 32'h0000_3008, 1'b0, '0);

        // Same index, other tag, then a write racing a lookup
        drive_cycle(1'b1, 32'h0000_1200, 1'b0, '0);
        drive_cycle(1'b1, 32'h0000_4010, 1'b1,
                    make_update(32'h0000_4010, 32'h0000_5000, 1'b0, 1'b1, 1'b1));
        drive_cycle(1'b1, 32'h0000_4010, 1'b0, '0);

        // Mixed random stream over an aliasing address pool
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            u = make_update(pool_addr(), addr_t'($urandom) & ~addr_t'(1), 1'b0, 1'b0,
                            1'($urandom % 2));
            if ($urandom % 3 == 1) begin
                u.is_jump = 1'b1;
                u.taken = 1'b1;
            end else begin
                u.is_branch = 1'b1;
            end
            drive_cycle(($urandom % 4) != 0, pool_addr(), 1'($urandom % 2), u);
        end

        idle_cycles(4);
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
        idle_cycles(4);
        $display("Test completed successfully");
        $finish;
    end

endmodule : branch_predictor_tb

`default_nettype wire

// ==== files.f ====
+incdir+include
verilog/core_addr_pkg.sv
verilog/branch_pred_pkg.sv
verilog/pred_table.sv
verilog/branch_target_buffer.sv
verilog/direction_predictor.sv
verilog/prediction_merge.sv
verilog/branch_predictor.sv
dv/branch_predictor_chk.sv
dv/branch_predictor_tb.sv

// ==== include/bpu_consts.svh ====
// ----------------------------------------------------------
// Sizing constants for the branch prediction unit
// Included by the prediction packages and the testbench so
// that table depths and widths are defined once
// ----------------------------------------------------------

`ifndef BPU_CONSTS_SVH
`define BPU_CONSTS_SVH

// Width of a byte address in the core
`define BPU_ADDR_W 32

// Entries in the direct-mapped branch target buffer
`define BPU_BTB_ENTRIES 256

// Entries in the bimodal counter table
`define BPU_BHT_ENTRIES 512

// Saturating counter width and the value of a counter never written
`define BPU_CNT_W 2
`define BPU_CNT_INIT 1

`endif

// ==== verilog/branch_pred_pkg.sv ====
// ----------------------------------------------------------
// Types exchanged inside the branch prediction unit and with
// fetch and execute
// Import this after core_addr_pkg has been compiled
// ----------------------------------------------------------

`default_nettype none

`include "bpu_consts.svh"

package branch_pred_pkg;

    import core_addr_pkg::*;

    // Fetch request for one program counter
    typedef struct packed {
        addr_t pc;
    } lookup_t;

    // Resolved control-flow instruction coming back from execute
    typedef struct packed {
        addr_t instr_addr;
        addr_t target;
        logic  is_branch;
        logic  is_jump;
        logic  taken;
    } update_t;

    // Target buffer entry, the tag starts just above the index bits
    typedef struct packed {
        logic                                          is_branch;
        logic [`BPU_ADDR_W-1:$clog2(`BPU_BTB_ENTRIES)+1] tag;
        addr_t                                         target;
    } btb_entry_t;

    // One bimodal saturating counter
    typedef struct packed {
        logic [`BPU_CNT_W-1:0] cnt;
    } cnt_entry_t;

    // What the target buffer knows about a lookup one cycle later
    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  hit;
        logic  is_jump;
        addr_t target;
    } btb_result_t;

    // Counter value for the same lookup
    typedef struct packed {
        logic [`BPU_CNT_W-1:0] cnt;
    } dir_result_t;

    // Final prediction handed back to fetch
    typedef struct packed {
        addr_t next_pc;
        logic  taken;
        logic  hit;
        addr_t pc;
    } prediction_t;

endpackage : branch_pred_pkg

`default_nettype wire

// ==== verilog/branch_predictor.sv ====
// ----------------------------------------------------------
// Branch prediction unit in front of the fetch stage
// A lookup gives its prediction exactly two cycles later and
// updates from execute may arrive in any cycle
// ----------------------------------------------------------

`default_nettype none

module branch_predictor (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    // Fetch request
    input  logic                         lookup_valid_i,
    input  branch_pred_pkg::lookup_t     lookup_i,
    // Resolved control flow from execute
    input  logic                         update_valid_i,
    input  branch_pred_pkg::update_t     update_i,
    // Prediction back to fetch
    output logic                         pred_valid_o,
    output branch_pred_pkg::prediction_t pred_o
);

    import branch_pred_pkg::*;

    btb_result_t btb_res;
    dir_result_t dir_res;

    // Both tables are read in parallel from the same pc
    branch_target_buffer btb_inst (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .lookup_valid_i (lookup_valid_i),
        .lookup_i       (lookup_i),
        .update_valid_i (update_valid_i),
        .update_i       (update_i),
        .btb_res_o      (btb_res)
    );

    // The counter table has no strobe of its own since the buffer carries it
    direction_predictor dir_inst (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .lookup_i       (lookup_i),
        .update_valid_i (update_valid_i),
        .update_i       (update_i),
        .dir_res_o      (dir_res)
    );

    prediction_merge merge_inst (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .btb_res_i    (btb_res),
        .dir_res_i    (dir_res),
        .pred_valid_o (pred_valid_o),
        .pred_o       (pred_o)
    );

endmodule : branch_predictor

`default_nettype wire

// ==== verilog/branch_target_buffer.sv ====
// ----------------------------------------------------------
// Direct-mapped branch target buffer
// Written by taken branches and all jumps from execute, read
// by every fetch lookup with the hit decided one cycle later
// ----------------------------------------------------------

`default_nettype none

`include "bpu_consts.svh"

module branch_target_buffer (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         lookup_valid_i,
    input  branch_pred_pkg::lookup_t     lookup_i,
    input  logic                         update_valid_i,
    input  branch_pred_pkg::update_t     update_i,
    output branch_pred_pkg::btb_result_t btb_res_o
);

    import core_addr_pkg::*;
    import branch_pred_pkg::*;

    // Index starts at bit 1 so compressed instructions get their own slot
    localparam int unsigned IDX_W = $clog2(`BPU_BTB_ENTRIES);
    localparam int unsigned TAG_LSB = IDX_W + 1;

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic             wr_en;
    btb_entry_t       wr_entry;
    btb_entry_t       rd_entry;
    logic             rd_valid;

    // ----------------------------------------------------------
    // Write side
    // ----------------------------------------------------------

    // Not-taken branches leave the buffer alone, jumps always write
    assign wr_en = update_valid_i &
                   ((update_i.is_branch & update_i.taken) | update_i.is_jump);
    assign wr_idx = update_i.instr_addr[IDX_W:1];

    assign wr_entry.is_branch = update_i.is_branch;
    assign wr_entry.tag       = update_i.instr_addr[`BPU_ADDR_W-1:TAG_LSB];
    assign wr_entry.target    = update_i.target;

    assign rd_idx = lookup_i.pc[IDX_W:1];

    pred_table #(
        .DEPTH   (`BPU_BTB_ENTRIES),
        .entry_t (btb_entry_t)
    ) table_inst (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .rd_idx_i     (rd_idx),
        .rd_entry_o   (rd_entry),
        .rd_valid_o   (rd_valid),
        .peek_idx_i   (wr_idx),
        .peek_entry_o (),
        .peek_valid_o (),
        .wr_en_i      (wr_en),
        .wr_idx_i     (wr_idx),
        .wr_entry_i   (wr_entry)
    );

    // ----------------------------------------------------------
    // Hit decision
    // ----------------------------------------------------------

    addr_t pc_q;
    logic  lookup_valid_q;

    // The pc is kept so its tag can meet the entry read in the next cycle
    always_ff @(posedge clk_i) begin
        pc_q <= lookup_i.pc;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lookup_valid_q <= 1'b0;
        end else begin
            lookup_valid_q <= lookup_valid_i;
        end
    end

    assign btb_res_o.valid   = lookup_valid_q;
    assign btb_res_o.pc      = pc_q;
    assign btb_res_o.hit     = rd_valid & (rd_entry.tag == pc_q[`BPU_ADDR_W-1:TAG_LSB]);
    // A stored entry that is not a branch can only be a jump
    assign btb_res_o.is_jump = btb_res_o.hit & ~rd_entry.is_branch;
    assign btb_res_o.target  = rd_entry.target;

endmodule : branch_target_buffer

`default_nettype wire

// ==== verilog/core_addr_pkg.sv ====
// ----------------------------------------------------------
// Basic address and instruction types of the core
// Imported by any block that carries program counters or
// raw instruction words
// ----------------------------------------------------------

`default_nettype none

`include "bpu_consts.svh"

package core_addr_pkg;

    // Byte address as seen by fetch and execute
    typedef logic [`BPU_ADDR_W-1:0] addr_t;

    // One uncompressed instruction word
    typedef logic [31:0] instr_t;

    // Compressed instructions are half a word wide
    typedef logic [15:0] instr_half_t;

endpackage : core_addr_pkg

`default_nettype wire

// ==== verilog/direction_predictor.sv ====
// ----------------------------------------------------------
// Bimodal direction predictor with 2-bit saturating counters
// Conditional branches from execute train the counter at
// their address, lookups read it one cycle later
// ----------------------------------------------------------

`default_nettype none

`include "bpu_consts.svh"

module direction_predictor (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  branch_pred_pkg::lookup_t     lookup_i,
    input  logic                         update_valid_i,
    input  branch_pred_pkg::update_t     update_i,
    output branch_pred_pkg::dir_result_t dir_res_o
);

    import branch_pred_pkg::*;

    localparam int unsigned IDX_W = $clog2(`BPU_BHT_ENTRIES);

    // Counter limits and the value seen before the first write
    localparam logic [`BPU_CNT_W-1:0] CNT_MAX  = '1;
    localparam logic [`BPU_CNT_W-1:0] CNT_MIN  = '0;
    localparam logic [`BPU_CNT_W-1:0] CNT_INIT = `BPU_CNT_W'(`BPU_CNT_INIT);

    logic [IDX_W-1:0]      rd_idx;
    logic [IDX_W-1:0]      wr_idx;
    logic                  wr_en;
    cnt_entry_t            rd_entry;
    logic                  rd_valid;
    cnt_entry_t            peek_entry;
    logic                  peek_valid;
    logic [`BPU_CNT_W-1:0] cur_cnt;
    cnt_entry_t            next_entry;

    assign rd_idx = lookup_i.pc[IDX_W:1];
    assign wr_idx = update_i.instr_addr[IDX_W:1];

    // Only conditional branches carry direction information
    assign wr_en = update_valid_i & update_i.is_branch;

    // ----------------------------------------------------------
    // Read-modify-write of the counter
    // ----------------------------------------------------------

    assign cur_cnt = peek_valid ? peek_entry.cnt : CNT_INIT;

    // Step towards the resolved direction and stop at either end
    always_comb begin
        next_entry.cnt = cur_cnt;
        if (update_i.taken) begin
            if (cur_cnt != CNT_MAX) begin
                next_entry.cnt = cur_cnt + 1'b1;
            end
        end else begin
            if (cur_cnt != CNT_MIN) begin
                next_entry.cnt = cur_cnt - 1'b1;
            end
        end
    end

    pred_table #(
        .DEPTH   (`BPU_BHT_ENTRIES),
        .entry_t (cnt_entry_t)
    ) table_inst (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .rd_idx_i     (rd_idx),
        .rd_entry_o   (rd_entry),
        .rd_valid_o   (rd_valid),
        .peek_idx_i   (wr_idx),
        .peek_entry_o (peek_entry),
        .peek_valid_o (peek_valid),
        .wr_en_i      (wr_en),
        .wr_idx_i     (wr_idx),
        .wr_entry_i   (next_entry)
    );

    // Lookups of an untrained counter see the same initial value
    assign dir_res_o.cnt = rd_valid ? rd_entry.cnt : CNT_INIT;

endmodule : direction_predictor

`default_nettype wire

// ==== verilog/pred_table.sv ====
// ----------------------------------------------------------
// Prediction storage shared by the target buffer and the
// counter table. One registered read port, one combinational
// peek port and one write port, generic over the entry type
// ----------------------------------------------------------

`default_nettype none

module pred_table #(
    parameter int unsigned DEPTH = 256,
    parameter type entry_t = logic
) (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    // Registered read port used by lookups
    input  logic [$clog2(DEPTH)-1:0] rd_idx_i,
    output entry_t                   rd_entry_o,
    output logic                     rd_valid_o,
    // Combinational read port used for read-modify-write
    input  logic [$clog2(DEPTH)-1:0] peek_idx_i,
    output entry_t                   peek_entry_o,
    output logic                     peek_valid_o,
    // Write port
    input  logic                     wr_en_i,
    input  logic [$clog2(DEPTH)-1:0] wr_idx_i,
    input  entry_t                   wr_entry_i
);

    // ----------------------------------------------------------
    // Storage
    // ----------------------------------------------------------

    entry_t mem_q [DEPTH];

    // One valid bit per entry, an entry stays invalid until its first write
    logic [DEPTH-1:0] valid_q;

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem_q[wr_idx_i] <= wr_entry_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_idx_i] <= 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Read ports
    // ----------------------------------------------------------

    // Nonblocking reads return the contents from before a same-cycle write
    always_ff @(posedge clk_i) begin
        rd_entry_o <= mem_q[rd_idx_i];
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= valid_q[rd_idx_i];
        end
    end

    // The peek port sees every write from earlier edges immediately
    assign peek_entry_o = mem_q[peek_idx_i];
    assign peek_valid_o = valid_q[peek_idx_i];

endmodule : pred_table

`default_nettype wire

// ==== verilog/prediction_merge.sv ====
// ----------------------------------------------------------
// Final stage of the predictor
// Combines the target buffer result with the counter and
// registers the next fetch address for the lookup
// ----------------------------------------------------------

`default_nettype none

module prediction_merge (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  branch_pred_pkg::btb_result_t btb_res_i,
    input  branch_pred_pkg::dir_result_t dir_res_i,
    output logic                         pred_valid_o,
    output branch_pred_pkg::prediction_t pred_o
);

    import core_addr_pkg::*;
    import branch_pred_pkg::*;

    addr_t       seq_pc;
    logic        cnt_taken;
    prediction_t pred_d;

    // Fall-through address for an uncompressed instruction
    assign seq_pc = btb_res_i.pc + addr_t'(4);

    // Upper half of the counter range means taken
    assign cnt_taken = dir_res_i.cnt[$bits(dir_res_i.cnt)-1];

    // ----------------------------------------------------------
    // Taken rule
    // ----------------------------------------------------------

    // Jumps are always taken, branches follow their counter
    always_comb begin
        pred_d.hit     = btb_res_i.hit;
        pred_d.taken   = btb_res_i.hit & (btb_res_i.is_jump | cnt_taken);
        pred_d.pc      = btb_res_i.pc;
        pred_d.next_pc = pred_d.taken ? btb_res_i.target : seq_pc;
    end

    // ----------------------------------------------------------
    // Output register
    // ----------------------------------------------------------

    always_ff @(posedge clk_i) begin
        pred_o <= pred_d;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pred_valid_o <= 1'b0;
        end else begin
            pred_valid_o <= btb_res_i.valid;
        end
    end

endmodule : prediction_merge

`default_nettype wire
